// ==== list.f ====
rtl/uart_mem_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_mem_ctrl.sv
rtl/uart_mem_bridge.sv
verif/uart_mem_model.sv
verif/uart_mem_bridge_assert.sv
verif/tb_uart_mem_bridge.sv

// ==== rtl/uart_mem_bridge.sv ====
`timescale 1ns/1ps

module uart_mem_bridge #(
    parameter logic [15:0] clks_per_bit  = uart_mem_pkg::def_clks_per_bit,
    parameter logic [23:0] reply_timeout = uart_mem_pkg::def_reply_timeout
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_req,
    input  uart_mem_pkg::mem_cmd_t cmd,
    output logic                   cmd_ack,
    output uart_mem_pkg::mem_rsp_t rsp,
    input  logic                   uart_rx,
    output logic                   uart_tx
);

    logic       tx_req;
    logic [7:0] tx_byte;
    logic       tx_ack;
    logic [7:0] rx_byte;
    logic       rx_valid;

    uart_mem_ctrl #(
        .reply_timeout(reply_timeout)
    ) i_uart_mem_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .rsp     (rsp),
        .tx_req  (tx_req),
        .tx_byte (tx_byte),
        .tx_ack  (tx_ack),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .tx_req (tx_req),
        .tx_byte(tx_byte),
        .tx_ack (tx_ack),
        .uart_tx(uart_tx)
    );

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

endmodule

// ==== rtl/uart_mem_ctrl.sv ====
`timescale 1ns/1ps

module uart_mem_ctrl #(
    parameter logic [23:0] reply_timeout = uart_mem_pkg::def_reply_timeout
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_req,
    input  uart_mem_pkg::mem_cmd_t cmd,
    output logic                  cmd_ack,
    output uart_mem_pkg::mem_rsp_t rsp,
    output logic                  tx_req,
    output logic [7:0]            tx_byte,
    input  logic                  tx_ack,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND,
        S_WAIT_ACK,
        S_REPLY,
        S_DONE
    } ctrl_state_t;

    ctrl_state_t            state;
    uart_mem_pkg::mem_cmd_t cmd_q;
    logic [3:0]             byte_cnt;
    logic [3:0]             last_byte;
    logic [7:0]             next_byte;
    logic [31:0]            reply_word;
    logic [23:0]            timer;

    // ======================================================================
    // Outgoing byte selection.
    // ======================================================================

    // Byte 0 is the opcode, 1 to 4 the address and 5 to 8 the write data,
    // both most significant byte first.
    always_comb begin
        case (byte_cnt)
            4'd0:    next_byte = cmd_q.write ? uart_mem_pkg::op_write : uart_mem_pkg::op_read;
            4'd1:    next_byte = cmd_q.addr[31:24];
            4'd2:    next_byte = cmd_q.addr[23:16];
            4'd3:    next_byte = cmd_q.addr[15:8];
            4'd4:    next_byte = cmd_q.addr[7:0];
            4'd5:    next_byte = cmd_q.wdata[31:24];
            4'd6:    next_byte = cmd_q.wdata[23:16];
            4'd7:    next_byte = cmd_q.wdata[15:8];
            default: next_byte = cmd_q.wdata[7:0];
        endcase
    end

    assign last_byte = cmd_q.write ? 4'd8 : 4'd4;

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_req) begin
            cmd_q <= cmd;
        end
        if (state == S_SEND && !tx_ack) begin
            tx_byte <= next_byte;
        end
        if (state == S_REPLY && rx_valid) begin
            reply_word <= {reply_word[23:0], rx_byte};
        end
    end

    // ======================================================================
    // Command sequencing.
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            byte_cnt <= '0;
            timer    <= '0;
            tx_req   <= 1'b0;
            cmd_ack  <= 1'b0;
            rsp      <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_req) begin
                        byte_cnt <= '0;
                        rsp      <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    // The previous exchange must be fully closed first.
                    if (!tx_ack) begin
                        tx_req <= 1'b1;
                        state  <= S_WAIT_ACK;
                    end
                end
                S_WAIT_ACK: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        if (byte_cnt != last_byte) begin
                            byte_cnt <= byte_cnt + 4'd1;
                            state    <= S_SEND;
                        end else if (cmd_q.write) begin
                            cmd_ack <= 1'b1;
                            state   <= S_DONE;
                        end else begin
                            byte_cnt <= '0;
                            timer    <= '0;
                            state    <= S_REPLY;
                        end
                    end
                end
                S_REPLY: begin
                    if (rx_valid) begin
                        timer    <= '0;
                        byte_cnt <= byte_cnt + 4'd1;
                        if (byte_cnt == 4'd3) begin
                            rsp.rdata <= {reply_word[23:0], rx_byte};
                            cmd_ack   <= 1'b1;
                            state     <= S_DONE;
                        end
                    end else if (timer == reply_timeout - 24'd1) begin
                        // Give up on the reply; rdata stays zero.
                        rsp.timeout <= 1'b1;
                        cmd_ack     <= 1'b1;
                        state       <= S_DONE;
                    end else begin
                        timer <= timer + 24'd1;
                    end
                end
                default: begin
                    // Hold the response until the client lets go.
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/uart_mem_pkg.sv ====
package uart_mem_pkg;

    // ======================================================================
    // Client command and response.
    // ======================================================================

    // One client request. The data word is ignored on a read.
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_cmd_t;

    // One result. The data word is zero for writes and for timeouts.
    typedef struct packed {
        logic [31:0] rdata;
        logic        timeout;
    } mem_rsp_t;

    // ======================================================================
    // Serial protocol.
    // ======================================================================

    // First byte of every command on the serial line.
    localparam logic [7:0] op_read  = 8'h00;
    localparam logic [7:0] op_write = 8'h01;

    // 27 MHz clock at 115200 baud.
    localparam logic [15:0] def_clks_per_bit = 16'd234;

    // Cycles allowed between reply bytes, a little over 20 byte times at the default rate.
    localparam logic [23:0] def_reply_timeout = 24'd50000;

endpackage

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter logic [15:0] clks_per_bit = uart_mem_pkg::def_clks_per_bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam logic [15:0] half_bit = clks_per_bit >> 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP,
        S_WAIT_IDLE
    } rx_state_t;

    rx_state_t   state;
    logic [1:0]  sync;
    logic        rx_prev;
    logic [15:0] bit_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shift;

    assign rx_byte = shift;

    // Two-flop synchronizer, plus one more flop for edge detection.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync    <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync    <= {sync[0], uart_rx};
            rx_prev <= sync[1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rx_prev && !sync[1]) begin
                        state   <= S_START;
                        bit_cnt <= '0;
                    end
                end
                S_START: begin
                    // A glitch that is gone by mid-bit is not a start bit.
                    if (bit_cnt == half_bit - 16'd1) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= sync[1] ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == clks_per_bit - 16'd1) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                S_STOP: begin
                    if (bit_cnt == clks_per_bit - 16'd1) begin
                        bit_cnt  <= '0;
                        rx_valid <= sync[1];
                        state    <= sync[1] ? S_IDLE : S_WAIT_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                default: begin
                    if (sync[1]) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first, so they shift in from the top.
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_cnt == clks_per_bit - 16'd1) begin
            shift <= {sync[1], shift[7:1]};
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter logic [15:0] clks_per_bit = uart_mem_pkg::def_clks_per_bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_req,
    input  logic [7:0] tx_byte,
    output logic       tx_ack,
    output logic       uart_tx
);

    // The frame goes out from bit 0: start bit, data LSB first, stop bit.
    // Ones are shifted in behind it, so the line returns to idle by itself.
    logic [9:0]  frame;
    logic [15:0] bit_cnt;
    logic [3:0]  bit_idx;
    logic        busy;

    assign uart_tx = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame   <= '1;
            bit_cnt <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
            tx_ack  <= 1'b0;
        end else begin
            if (!busy) begin
                if (tx_req && !tx_ack) begin
                    frame   <= {1'b1, tx_byte, 1'b0};
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    busy    <= 1'b1;
                end else if (!tx_req) begin
                    tx_ack <= 1'b0;
                end
            end else if (bit_cnt == clks_per_bit - 16'd1) begin
                bit_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                if (bit_idx == 4'd9) begin
                    // The stop bit has been on the line for a full bit time.
                    busy   <= 1'b0;
                    tx_ack <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                bit_cnt <= bit_cnt + 16'd1;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_uart_mem_bridge -f list.f -o tb_uart_mem_bridge
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/tb_uart_mem_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    echo "Test passed."
    exit 0
else
    echo "Test failed because the pass message is missing from sim.log."
    exit 1
fi

// ==== verif/tb_uart_mem_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_mem_bridge;

    localparam logic [15:0] clks_per_bit  = 16'd8;
    localparam logic [23:0] reply_timeout = 24'd200;
    localparam int          wait_limit    = 2000;
    localparam int unsigned seed          = 16931;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_req;
    uart_mem_pkg::mem_cmd_t cmd;
    logic                   cmd_ack;
    uart_mem_pkg::mem_rsp_t rsp;
    logic                   uart_tx;
    logic                   uart_rx;
    logic                   mute;

    uart_mem_bridge #(
        .clks_per_bit (clks_per_bit),
        .reply_timeout(reply_timeout)
    ) i_uart_mem_bridge (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd_req(cmd_req),
        .cmd    (cmd),
        .cmd_ack(cmd_ack),
        .rsp    (rsp),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx)
    );

    // The serial wires cross between the bridge and the remote memory.
    uart_mem_model #(
        .clks_per_bit(clks_per_bit)
    ) i_uart_mem_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .mute    (mute),
        .line_in (uart_tx),
        .line_out(uart_rx)
    );

    always #5 clk = ~clk;

    // ===================================================================
    // Checks and handshake helpers.
    // ===================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_rsp(input uart_mem_pkg::mem_rsp_t got,
                             input uart_mem_pkg::mem_rsp_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s rsp rdata=%h timeout=%b, expected rdata=%h timeout=%b",
                                $time, what, got.rdata, got.timeout, exp.rdata, exp.timeout));
        end
    endtask

    task automatic check_idle(input logic line);
        if (line !== 1'b1) begin
            abort_run($sformatf("ERR %0t: uart_tx is %b, expected idle high", $time, line));
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (cmd_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles >= wait_limit) begin
                abort_run($sformatf("Timed out after %0d cycles waiting for cmd_ack to be %b.",
                                    wait_limit, level));
            end
        end
    endtask

    task automatic run_command(input uart_mem_pkg::mem_cmd_t c, input logic m,
                               input uart_mem_pkg::mem_rsp_t exp, input int idx);
        int    idle;
        int    hold;
        string what;
        idle = $urandom_range(20, 0);
        hold = $urandom_range(5, 0);
        what = $sformatf("command %0d", idx);
        repeat (idle) @(negedge clk);
        check_idle(uart_tx);
        cmd     = c;
        mute    = m;
        cmd_req = 1'b1;
        wait_ack(1'b1);
        check_rsp(rsp, exp, what);
        // Keep the request up a while; the response must not move.
        repeat (hold) @(negedge clk);
        check_rsp(rsp, exp, what);
        cmd_req = 1'b0;
        wait_ack(1'b0);
    endtask

    // ===================================================================
    // Pattern replay.
    // ===================================================================

    initial begin
        int                     fd;
        int                     n_cmds;
        string                  line;
        logic                   w;
        logic [31:0]            a;
        logic [31:0]            d;
        logic                   m;
        logic [31:0]            exp_rdata;
        logic                   exp_timeout;
        uart_mem_pkg::mem_cmd_t c;
        uart_mem_pkg::mem_rsp_t exp;

        clk     = 1'b0;
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        mute    = 1'b0;
        n_cmds  = 0;
        void'($urandom(seed));

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle(uart_tx);
        check_rsp(rsp, '0, "after reset");

        fd = $fopen("verif/uart_mem_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the pattern file verif/uart_mem_patterns.txt.");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment lines and blank lines do not scan as six fields.
            if ($sscanf(line, "%h %h %h %h %h %h", w, a, d, m, exp_rdata, exp_timeout) == 6) begin
                c.write     = w;
                c.addr      = a;
                c.wdata     = d;
                exp.rdata   = exp_rdata;
                exp.timeout = exp_timeout;
                run_command(c, m, exp, n_cmds);
                n_cmds++;
            end
        end
        $fclose(fd);

        if (n_cmds == 0) begin
            abort_run("The pattern file held no commands.");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== verif/uart_mem_bridge_assert.sv ====
`timescale 1ns/1ps

module uart_mem_bridge_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cmd_req,
    input logic                   cmd_ack,
    input uart_mem_pkg::mem_rsp_t rsp,
    input logic                   tx_req,
    input logic                   tx_ack
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without a pending cmd_req");

    rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && $past(cmd_ack) |-> $stable(rsp))
        else $error("rsp changed while cmd_ack was high");

    // Each byte is a full four-phase exchange with the transmitter.
    tx_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(tx_req) |-> $past(tx_ack))
        else $error("tx_req fell before tx_ack rose");

    ack_low_in_reset: assert property (@(posedge clk) !rst_n |-> !cmd_ack)
        else $error("cmd_ack was high during reset");

endmodule

bind uart_mem_ctrl uart_mem_bridge_assert i_uart_mem_bridge_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .rsp    (rsp),
    .tx_req (tx_req),
    .tx_ack (tx_ack)
);

// ==== verif/uart_mem_model.sv ====
`timescale 1ns/1ps

module uart_mem_model #(
    parameter logic [15:0] clks_per_bit = uart_mem_pkg::def_clks_per_bit
) (
    input  logic clk,
    input  logic rst_n,
    input  logic mute,
    input  logic line_in,
    output logic line_out
);

    logic [31:0] mem [16];

    // Returns at the middle of the stop bit, so a reply can start right away.
    task automatic get_byte(output logic [7:0] b);
        @(negedge line_in);
        repeat (clks_per_bit / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(posedge clk);
            b = {line_in, b[7:1]};
        end
        repeat (clks_per_bit) @(posedge clk);
    endtask

    task automatic put_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            line_out = frame[0];
            frame    = {1'b1, frame[9:1]};
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    initial begin
        logic [7:0]  op;
        logic [7:0]  b;
        logic [31:0] addr;
        logic [31:0] data;
        logic        quiet;
        line_out = 1'b1;
        mem      = '{default: '0};
        @(posedge rst_n);
        forever begin
            get_byte(op);
            quiet = mute;
            for (int i = 0; i < 4; i++) begin
                get_byte(b);
                addr = {addr[23:0], b};
            end
            if (op == uart_mem_pkg::op_write) begin
                for (int i = 0; i < 4; i++) begin
                    get_byte(b);
                    data = {data[23:0], b};
                end
                if (!quiet) begin
                    mem[addr[5:2]] = data;
                end
            end else if (!quiet) begin
                data = mem[addr[5:2]];
                for (int i = 0; i < 4; i++) begin
                    put_byte(data[31:24]);
                    data = data << 8;
                end
            end
        end
    end

endmodule

// ==== verif/uart_mem_patterns.txt ====
# Columns: write addr wdata mute expected_rdata expected_timeout, all hex.
# The model keeps 16 words selected by addr[5:2] and stays silent while muted.
0 00000010 FFFFFFFF 0 00000000 0
1 00000010 12345678 0 00000000 0
0 00000010 00000000 0 12345678 0
1 0000003C DEADBEEF 0 00000000 0
1 A5000004 CAFEF00D 0 00000000 0
0 0000003C 00000000 0 DEADBEEF 0
0 00000004 00000000 1 00000000 1
0 00000004 00000000 0 CAFEF00D 0
0 00000020 00000000 0 00000000 0
1 00000010 0BADF00D 0 00000000 0
0 00000010 00000000 0 0BADF00D 0
